/* dv/ioTb.sv */
module ioTb;

    logic                        clk2p5 = 1'b0;
    logic                        rst;
    logic                        clkEn;
    logic                        hostStrobe;
    logic                        hostWrite;
    logic [ioPkg::addrWidth-1:0] hostAddr;
    logic [ioPkg::dataWidth-1:0] hostWdata;
    logic                        hostDone;
    logic [ioPkg::dataWidth-1:0] hostRdata;
    logic [ioPkg::pinCount-1:0]  pinIn;
    logic [ioPkg::pinCount-1:0]  pinOut;
    logic [ioPkg::pinCount-1:0]  pinOutEnable;

    // Scoreboard copy of the 32 cells
    logic [ioPkg::pinCount-1:0] modelOut = '0;
    logic [ioPkg::pinCount-1:0] modelEn = '0;

    int errorCount = 0;
    int checkCount = 0;
    int testsRun = 0;
    int testsFailed = 0;

    ioSubsystemTop i_dut (
        .clk2p5       (clk2p5),
        .rst          (rst),
        .clkEn        (clkEn),
        .hostStrobe   (hostStrobe),
        .hostWrite    (hostWrite),
        .hostAddr     (hostAddr),
        .hostWdata    (hostWdata),
        .hostDone     (hostDone),
        .hostRdata    (hostRdata),
        .pinIn        (pinIn),
        .pinOut       (pinOut),
        .pinOutEnable (pinOutEnable)
    );

    always #5 clk2p5 = ~clk2p5;

    function automatic logic [ioPkg::addrWidth-1:0] makeAddr(input logic [4:0] pin,
                                                             input logic [2:0] op);
        logic [ioPkg::addrWidth-1:0] addr;
        addr = '0;
        addr[ioPkg::pinSelMsb:ioPkg::pinSelLsb] = pin;
        addr[ioPkg::opMsb:ioPkg::opLsb] = op;
        return addr;
    endfunction

    // Cell rules; pinIn is held stable long enough to equal the synchronizer output
    task automatic applyModel(input logic write, input logic [4:0] pin, input logic [2:0] op,
                              input logic dataBit, output logic [ioPkg::dataWidth-1:0] expData);
        expData = '0;
        case (op)
            ioPkg::opSet: begin
                modelOut[pin] = dataBit;
                modelEn[pin]  = 1'b1;
            end
            ioPkg::opToggle: begin
                modelOut[pin] = ~modelOut[pin];
            end
            ioPkg::opRelease: begin
                modelEn[pin] = 1'b0;
            end
            ioPkg::opRead: begin
                if (!write) begin
                    expData[0] = pinIn[pin];
                end
            end
            default: begin
            end
        endcase
    endtask

    task automatic compareData(input string name, input logic [ioPkg::dataWidth-1:0] actual,
                               input logic [ioPkg::dataWidth-1:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
        end
    endtask

    task automatic comparePins(input logic [ioPkg::pinCount-1:0] actOut,
                               input logic [ioPkg::pinCount-1:0] actEn,
                               input logic [ioPkg::pinCount-1:0] expOut,
                               input logic [ioPkg::pinCount-1:0] expEn);
        checkCount += 2;
        if (actOut !== expOut) begin
            errorCount++;
            $display("[ERROR] pinOut: got 0x%h, expected 0x%h", actOut, expOut);
        end
        if (actEn !== expEn) begin
            errorCount++;
            $display("[ERROR] pinOutEnable: got 0x%h, expected 0x%h", actEn, expEn);
        end
    endtask

    task automatic waitDone(output bit completed);
        int waitCycles;
        waitCycles = 0;
        while (hostDone !== 1'b1 && waitCycles < 50) begin
            @(negedge clk2p5);
            waitCycles++;
        end
        completed = (hostDone === 1'b1);
        if (!completed) begin
            errorCount++;
            $display("Timeout: hostDone did not rise within 50 cycles of the strobe");
        end
    endtask

    task automatic hostAccess(input logic write, input logic [ioPkg::addrWidth-1:0] addr,
                              input logic [ioPkg::dataWidth-1:0] wdata,
                              output logic [ioPkg::dataWidth-1:0] rdata, output bit completed);
        @(negedge clk2p5);
        hostStrobe = 1'b1;
        hostWrite  = write;
        hostAddr   = addr;
        hostWdata  = wdata;
        @(negedge clk2p5);
        hostStrobe = 1'b0;
        waitDone(completed);
        rdata = hostRdata;
    endtask

    task automatic checkedAccess(input logic write, input logic [4:0] pin, input logic [2:0] op,
                                 input logic [ioPkg::dataWidth-1:0] data);
        logic [ioPkg::dataWidth-1:0] expData;
        logic [ioPkg::dataWidth-1:0] rdata;
        bit                          completed;
        applyModel(write, pin, op, data[0], expData);
        hostAccess(write, makeAddr(pin, op), data, rdata, completed);
        if (completed) begin
            compareData("hostRdata", rdata, expData);
            comparePins(pinOut, pinOutEnable, modelOut, modelEn);
        end
    endtask

    task automatic finishTest(input string name, input int startErrors);
        testsRun++;
        if (errorCount > startErrors) begin
            testsFailed++;
            $display("%s: FAIL, %0d errors", name, errorCount - startErrors);
        end else begin
            $display("%s: PASS", name);
        end
    endtask

    task automatic resetStateTest();
        int         startErrors;
        logic [4:0] pin;
        startErrors = errorCount;
        comparePins(pinOut, pinOutEnable, '0, '0);
        repeat (4) begin
            pin = 5'($urandom);
            checkedAccess(1'b0, pin, ioPkg::opRead, 16'h0);
        end
        finishTest("reset state", startErrors);
    endtask

    task automatic setReleaseTest();
        int         startErrors;
        logic [4:0] pin;
        startErrors = errorCount;
        pin = '0;
        repeat (32) begin
            pin = 5'($urandom);
            checkedAccess(1'b1, pin, ioPkg::opSet, 16'($urandom));
        end
        // Last set pin is enabled, so release must clear exactly that bit
        checkedAccess(1'b1, pin, ioPkg::opRelease, 16'($urandom));
        finishTest("set and release", startErrors);
    endtask

    task automatic toggleTest();
        int                         startErrors;
        logic [4:0]                 pin;
        logic [ioPkg::pinCount-1:0] beforeOut;
        logic [ioPkg::pinCount-1:0] beforeEn;
        startErrors = errorCount;
        pin = 5'($urandom);
        beforeOut = pinOut;
        beforeEn = pinOutEnable;
        checkedAccess(1'b1, pin, ioPkg::opToggle, 16'h0);
        checkCount++;
        if (pinOut[pin] !== ~beforeOut[pin]) begin
            errorCount++;
            $display("[ERROR] pinOut[%0d]: got 0x%h, expected 0x%h", pin, pinOut[pin],
                     ~beforeOut[pin]);
        end
        checkedAccess(1'b1, pin, ioPkg::opToggle, 16'h0);
        comparePins(pinOut, pinOutEnable, beforeOut, beforeEn);
        finishTest("toggle", startErrors);
    endtask

    task automatic readTest();
        int         startErrors;
        int         idx;
        logic [4:0] pin;
        logic [2:0] otherOps [5] = '{3'd0, 3'd2, 3'd5, 3'd6, 3'd7};
        startErrors = errorCount;
        @(negedge clk2p5);
        pinIn = $urandom;
        // Two synchronizer stages plus margin
        repeat (3) @(negedge clk2p5);
        for (idx = 0; idx < ioPkg::pinCount; idx++) begin
            checkedAccess(1'b0, 5'(idx), ioPkg::opRead, 16'($urandom));
        end
        pin = 5'($urandom);
        checkedAccess(1'b1, pin, ioPkg::opRead, 16'($urandom));
        for (idx = 0; idx < 5; idx++) begin
            pin = 5'($urandom);
            checkedAccess(1'b0, pin, otherOps[idx], 16'($urandom));
        end
        finishTest("read", startErrors);
    endtask

    task automatic stalledAccess(input logic write, input logic [4:0] pin, input logic [2:0] op,
                                 input logic [ioPkg::dataWidth-1:0] data, input int stallCycles);
        logic [ioPkg::dataWidth-1:0] expData;
        bit                          completed;
        @(negedge clk2p5);
        hostStrobe = 1'b1;
        hostWrite  = write;
        hostAddr   = makeAddr(pin, op);
        hostWdata  = data;
        clkEn      = 1'b0;
        @(negedge clk2p5);
        hostStrobe = 1'b0;
        repeat (stallCycles) begin
            checkCount++;
            if (hostDone !== 1'b0) begin
                errorCount++;
                $display("[ERROR] hostDone: got 0x%h, expected 0x0 during stall", hostDone);
            end
            comparePins(pinOut, pinOutEnable, modelOut, modelEn);
            @(negedge clk2p5);
        end
        clkEn = 1'b1;
        applyModel(write, pin, op, data[0], expData);
        waitDone(completed);
        if (completed) begin
            compareData("hostRdata", hostRdata, expData);
            comparePins(pinOut, pinOutEnable, modelOut, modelEn);
        end
    endtask

    task automatic stallTest();
        int         startErrors;
        logic [4:0] pin;
        startErrors = errorCount;
        pin = 5'($urandom);
        // Opposite data bit so a set leaking through the stall shows on the pin
        stalledAccess(1'b1, pin, ioPkg::opSet, {15'($urandom), ~pinOut[pin]},
                      2 + $urandom_range(8, 0));
        stalledAccess(1'b0, 5'($urandom), ioPkg::opRead, 16'h0, 2 + $urandom_range(8, 0));
        finishTest("clock-enable stall", startErrors);
    endtask

    task automatic decodeTest();
        int                         startErrors;
        int                         k;
        logic [4:0]                 pin;
        logic [ioPkg::pinCount-1:0] beforeOut;
        logic [ioPkg::pinCount-1:0] beforeEn;
        logic [ioPkg::pinCount-1:0] diff;
        int                         decodePins [4] = '{0, 15, 16, 31};
        startErrors = errorCount;
        for (k = 0; k < 4; k++) begin
            pin = 5'(decodePins[k]);
            beforeOut = pinOut;
            beforeEn = pinOutEnable;
            // Opposite data bit so the own pin must change
            checkedAccess(1'b1, pin, ioPkg::opSet, {15'($urandom), ~pinOut[pin]});
            diff = (beforeOut ^ pinOut) | (beforeEn ^ pinOutEnable);
            checkCount++;
            if ((diff & ~(32'h1 << pin)) != '0) begin
                errorCount++;
                $display("Access to pin %0d also changed other pins, change mask 0x%h",
                         pin, diff);
            end
        end
        finishTest("decode isolation", startErrors);
    endtask

    initial begin
        void'($urandom(32'hcd0c));
        rst        = 1'b1;
        clkEn      = 1'b1;
        hostStrobe = 1'b0;
        hostWrite  = 1'b0;
        hostAddr   = '0;
        hostWdata  = '0;
        pinIn      = '0;
        repeat (10) @(negedge clk2p5);
        rst = 1'b0;

        resetStateTest();
        setReleaseTest();
        toggleTest();
        readTest();
        stallTest();
        decodeTest();

        $display("Tests run: %0d, tests failed: %0d, checks: %0d, errors: %0d",
                 testsRun, testsFailed, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* dv/ioTb_props.sv */
module ioTbProps (
    input logic                        clk2p5,
    input logic                        rst,
    input logic                        clkEn,
    input logic                        req,
    input logic                        ack,
    input logic [ioPkg::dataWidth-1:0] resultData
);

    // Ack one enabled edge after req
    ackFollowsReq: assert property (@(posedge clk2p5) disable iff (rst)
        (clkEn && req) |=> ack)
        else $error("ack missing one enabled cycle after req");

    // A rising ack needs an enabled req on the edge before
    ackNeedsReq: assert property (@(posedge clk2p5) disable iff (rst)
        $rose(ack) |-> $past(clkEn && req))
        else $error("ack rose without a prior req");

    // Ack lasts one enabled cycle
    ackSinglePulse: assert property (@(posedge clk2p5) disable iff (rst)
        (clkEn && !req) |=> !ack)
        else $error("ack still high one enabled cycle after req dropped");

    resultZeroWithoutAck: assert property (@(posedge clk2p5) disable iff (rst)
        !ack |-> (resultData == '0))
        else $error("resultData nonzero while ack is low");

endmodule

bind ioController ioTbProps propsInst (
    .clk2p5     (clk2p5),
    .rst        (rst),
    .clkEn      (clkEn),
    .req        (portBus.req),
    .ack        (portBus.ack),
    .resultData (portBus.resultData)
);

/* logic/hostBridge.sv */
module hostBridge (
    input  logic                        clk2p5,
    input  logic                        rst,
    input  logic                        clkEn,
    input  logic                        hostStrobe,
    input  logic                        hostWrite,
    input  logic [ioPkg::addrWidth-1:0] hostAddr,
    input  logic [ioPkg::dataWidth-1:0] hostWdata,
    output logic                        hostDone,
    output logic [ioPkg::dataWidth-1:0] hostRdata,
    ioPortIf.requester                  portBus
);

    logic                        reqReg;
    ioPkg::portCmdE              cmdReg;
    logic [ioPkg::addrWidth-1:0] addrReg;
    logic [ioPkg::dataWidth-1:0] wdataReg;
    logic                        doneReg;
    logic [ioPkg::dataWidth-1:0] rdataReg;

    // Strobe is taken on any edge, req drops only on an enabled edge
    always_ff @(posedge clk2p5) begin
        if (rst) begin
            reqReg <= 1'b0;
            cmdReg <= ioPkg::cmdIdle;
        end else if (hostStrobe) begin
            reqReg <= 1'b1;
            cmdReg <= hostWrite ? ioPkg::cmdStore : ioPkg::cmdLoad;
        end else if (clkEn) begin
            reqReg <= 1'b0;
        end
    end

    // Request payload
    always_ff @(posedge clk2p5) begin
        if (hostStrobe) begin
            addrReg  <= hostAddr;
            wdataReg <= hostWdata;
        end
    end

    // Response side
    always_ff @(posedge clk2p5) begin
        if (rst) begin
            doneReg  <= 1'b0;
            rdataReg <= '0;
        end else if (clkEn) begin
            doneReg <= portBus.ack;
            if (portBus.ack) begin
                rdataReg <= portBus.resultData;
            end
        end
    end

    assign portBus.req           = reqReg;
    assign portBus.command       = cmdReg;
    assign portBus.remoteAddress = addrReg;
    assign portBus.writeData     = wdataReg;

    assign hostDone  = doneReg;
    // Held until the next completed access
    assign hostRdata = rdataReg;

endmodule

/* logic/inputSync.sv */
module inputSync (
    input  logic                       clk2p5,
    input  logic                       rst,
    input  logic [ioPkg::pinCount-1:0] pinIn,
    output logic [ioPkg::pinCount-1:0] pinSync
);

    logic [ioPkg::pinCount-1:0] stageOne;
    logic [ioPkg::pinCount-1:0] stageTwo;

    // Free running, not gated by clkEn
    always_ff @(posedge clk2p5) begin
        if (rst) begin
            stageOne <= '0;
            stageTwo <= '0;
        end else begin
            stageOne <= pinIn;
            stageTwo <= stageOne;
        end
    end

    assign pinSync = stageTwo;

endmodule

/* logic/ioCell.sv */
module ioCell (
    input  logic         clk2p5,
    input  logic         rst,
    input  logic         clkEn,
    input  logic         cellSelect,
    input  ioPkg::cellOpE cellOp,
    input  logic         dataIn,
    input  logic         pinSync,
    output logic         cellState,
    output logic         cellOut,
    output logic         cellOutEnable
);

    logic stateReg;
    logic outReg;
    logic enableReg;

    always_ff @(posedge clk2p5) begin
        if (rst) begin
            stateReg  <= 1'b0;
            outReg    <= 1'b0;
            enableReg <= 1'b0;
        end else if (clkEn && cellSelect) begin
            case (cellOp)
                ioPkg::opSet: begin
                    outReg    <= dataIn;
                    enableReg <= 1'b1;
                end
                ioPkg::opToggle: begin
                    outReg <= ~outReg;
                end
                ioPkg::opRelease: begin
                    // Driver off, last value kept
                    enableReg <= 1'b0;
                end
                ioPkg::opRead: begin
                    stateReg <= pinSync;
                end
                default: begin
                    stateReg  <= stateReg;
                    outReg    <= outReg;
                    enableReg <= enableReg;
                end
            endcase
        end
    end

    assign cellState     = stateReg;
    assign cellOut       = outReg;
    assign cellOutEnable = enableReg;

endmodule

/* logic/ioController.sv */
module ioController (
    input  logic                       clk2p5,
    input  logic                       rst,
    input  logic                       clkEn,
    ioPortIf.responder                 portBus,
    input  logic [ioPkg::pinCount-1:0] pinSync,
    output logic [ioPkg::pinCount-1:0] pinOut,
    output logic [ioPkg::pinCount-1:0] pinOutEnable
);

    logic [ioPkg::pinIdxWidth-1:0] pinNum;
    ioPkg::cellOpE                 cellOp;
    logic [ioPkg::pinCount-1:0]    pinSelect;
    logic [ioPkg::pinCount-1:0]    cellStates;
    logic                          dataBit;
    logic                          readReq;

    logic                          ackReg;
    logic                          readFlag;
    logic [ioPkg::pinIdxWidth-1:0] readPin;
    logic                          selectedState;

    // Address fields
    assign pinNum  = portBus.remoteAddress[ioPkg::pinSelMsb:ioPkg::pinSelLsb];
    assign cellOp  = ioPkg::cellOpE'(portBus.remoteAddress[ioPkg::opMsb:ioPkg::opLsb]);
    assign dataBit = portBus.writeData[0];

    // One-hot pin select, only while a request is present
    always_comb begin
        pinSelect = '0;
        if (portBus.req) begin
            pinSelect[pinNum] = 1'b1;
        end
    end

    // Read result only for a load carrying opRead
    assign readReq = portBus.req
                     && (portBus.command == ioPkg::cmdLoad)
                     && (cellOp == ioPkg::opRead);

    genvar i;
    generate
        for (i = 0; i < ioPkg::pinCount; i++) begin : cellGen
            ioCell cellInst (
                .clk2p5        (clk2p5),
                .rst           (rst),
                .clkEn         (clkEn),
                .cellSelect    (pinSelect[i]),
                .cellOp        (cellOp),
                .dataIn        (dataBit),
                .pinSync       (pinSync[i]),
                .cellState     (cellStates[i]),
                .cellOut       (pinOut[i]),
                .cellOutEnable (pinOutEnable[i])
            );
        end
    endgenerate

    // Ack and read flag advance on enabled edges only
    always_ff @(posedge clk2p5) begin
        if (rst) begin
            ackReg   <= 1'b0;
            readFlag <= 1'b0;
        end else if (clkEn) begin
            ackReg   <= portBus.req;
            readFlag <= readReq;
        end
    end

    // Pin of the pending read, kept with the flag
    always_ff @(posedge clk2p5) begin
        if (clkEn && portBus.req) begin
            readPin <= pinNum;
        end
    end

    // Cell state already holds the captured bit when the flag is set
    assign selectedState = cellStates[readPin];

    assign portBus.ack        = ackReg;
    assign portBus.resultData = readFlag ? {{(ioPkg::dataWidth-1){1'b0}}, selectedState}
                                         : '0;

endmodule

/* logic/ioPkg.sv */
package ioPkg;

    // Pin count is fixed by the 5-bit pin field of the address
    localparam int pinCount    = 32;
    localparam int pinIdxWidth = $clog2(pinCount);

    localparam int dataWidth = 16;
    localparam int addrWidth = 16;

    // Remote address layout
    localparam int pinSelLsb = 0;
    localparam int pinSelMsb = 4;
    localparam int opLsb     = 8;
    localparam int opMsb     = 10;

    // Host commands
    typedef enum logic [3:0] {
        cmdIdle  = 4'b0000,
        cmdStore = 4'b0010,
        cmdLoad  = 4'b0100
    } portCmdE;

    // Per-pin operations, unlisted codes act as opNone
    typedef enum logic [2:0] {
        opNone    = 3'b000,
        opSet     = 3'b001,
        opToggle  = 3'b010,
        opRelease = 3'b011,
        opRead    = 3'b100
    } cellOpE;

endpackage

/* logic/ioPortIf.sv */
interface ioPortIf;

    logic                            req;
    ioPkg::portCmdE                  command;
    logic [ioPkg::addrWidth-1:0]     remoteAddress;
    logic [ioPkg::dataWidth-1:0]     writeData;
    logic                            ack;
    logic [ioPkg::dataWidth-1:0]     resultData;

    // Bridge side
    modport requester (
        output req,
        output command,
        output remoteAddress,
        output writeData,
        input  ack,
        input  resultData
    );

    // Controller side
    modport responder (
        input  req,
        input  command,
        input  remoteAddress,
        input  writeData,
        output ack,
        output resultData
    );

endinterface

/* logic/ioSubsystemTop.sv */
module ioSubsystemTop (
    input  logic                        clk2p5,
    input  logic                        rst,
    input  logic                        clkEn,

    // Host side
    input  logic                        hostStrobe,
    input  logic                        hostWrite,
    input  logic [ioPkg::addrWidth-1:0] hostAddr,
    input  logic [ioPkg::dataWidth-1:0] hostWdata,
    output logic                        hostDone,
    output logic [ioPkg::dataWidth-1:0] hostRdata,

    // Pins
    input  logic [ioPkg::pinCount-1:0]  pinIn,
    output logic [ioPkg::pinCount-1:0]  pinOut,
    output logic [ioPkg::pinCount-1:0]  pinOutEnable
);

    logic [ioPkg::pinCount-1:0] pinSync;

    ioPortIf portBus ();

    hostBridge hostBridgeInst (
        .clk2p5     (clk2p5),
        .rst        (rst),
        .clkEn      (clkEn),
        .hostStrobe (hostStrobe),
        .hostWrite  (hostWrite),
        .hostAddr   (hostAddr),
        .hostWdata  (hostWdata),
        .hostDone   (hostDone),
        .hostRdata  (hostRdata),
        .portBus    (portBus.requester)
    );

    // Pin inputs into the clock domain
    inputSync inputSyncInst (
        .clk2p5  (clk2p5),
        .rst     (rst),
        .pinIn   (pinIn),
        .pinSync (pinSync)
    );

    ioController ioControllerInst (
        .clk2p5       (clk2p5),
        .rst          (rst),
        .clkEn        (clkEn),
        .portBus      (portBus.responder),
        .pinSync      (pinSync),
        .pinOut       (pinOut),
        .pinOutEnable (pinOutEnable)
    );

endmodule

/* sim.f */
logic/ioPkg.sv
logic/ioPortIf.sv
logic/ioCell.sv
logic/inputSync.sv
logic/ioController.sv
logic/hostBridge.sv
logic/ioSubsystemTop.sv
dv/ioTb_props.sv
dv/ioTb.sv
